/* isa_pkg.sv */
`default_nettype none

package isa_pkg;

  // rv32e keeps 16 registers
  // so bit 4 of every register field is dropped
  localparam int REG_IDX_W = 4;
  localparam int XLEN = 32;

  // major opcodes of the supported subset
  // loads, stores, fence and system are not decoded
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  // alu code is {funct7[5], funct3}
  // so r-type instructions map straight onto it
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  // branch condition, taken from funct3 as is
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } br_fn_e;

endpackage

`default_nettype wire

/* pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

  // one instruction word as handed over by fetch
  typedef struct packed {
    logic [31:0]              inst;
    logic [isa_pkg::XLEN-1:0] pc;
  } issue_t;

  // decoded instruction with operands already resolved
  typedef struct packed {
    logic [isa_pkg::XLEN-1:0]      pc;
    logic [isa_pkg::REG_IDX_W-1:0] rd;
    logic                          wen;
    logic [isa_pkg::XLEN-1:0]      op1;
    logic [isa_pkg::XLEN-1:0]      op2;
    isa_pkg::alu_op_e              alu_op;
    logic                          is_branch;
    logic                          is_jump;
    isa_pkg::br_fn_e               br_fn;
    // base for the branch or jump target adder
    logic [isa_pkg::XLEN-1:0]      jump_base;
    logic [isa_pkg::XLEN-1:0]      imm;
    logic                          illegal;
  } dec_t;

  // what leaves the core on the retire port
  typedef struct packed {
    logic [isa_pkg::XLEN-1:0]      pc;
    logic [isa_pkg::REG_IDX_W-1:0] rd;
    logic                          wen;
    logic [isa_pkg::XLEN-1:0]      value;
    logic                          taken;
    logic [isa_pkg::XLEN-1:0]      target;
    logic                          illegal;
  } retire_t;

endpackage

`default_nettype wire

/* idu_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module idu_decoder (
  input  wire logic [31:0]              inst_i,
  input  wire logic [isa_pkg::XLEN-1:0] pc_i,
  input  wire logic [isa_pkg::XLEN-1:0] rs1_val_i,
  input  wire logic [isa_pkg::XLEN-1:0] rs2_val_i,
  output pipe_pkg::dec_t                dec_o
);
  import isa_pkg::*;

  opcode_e               opcode;
  logic [REG_IDX_W-1:0]  rd;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [XLEN-1:0]       imm_i;
  logic [XLEN-1:0]       imm_u;
  logic [XLEN-1:0]       imm_b;
  logic [XLEN-1:0]       imm_j;

  assign opcode = opcode_e'(inst_i[6:0]);
  // bit 11 of rd is not used in rv32e
  assign rd     = inst_i[10:7];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];

  // immediates, all sign extended from bit 31
  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {inst_i[31:12], 12'b0};
  assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21],
                  1'b0};

  always_comb begin
    dec_o           = '0;
    dec_o.pc        = pc_i;
    dec_o.rd        = rd;
    dec_o.wen       = 1'b1;
    dec_o.alu_op    = ALU_ADD;
    dec_o.br_fn     = br_fn_e'(funct3);
    case (opcode)
      OPC_LUI: begin
        dec_o.op2 = imm_u;
        dec_o.imm = imm_u;
      end
      OPC_AUIPC: begin
        dec_o.op1 = pc_i;
        dec_o.op2 = imm_u;
        dec_o.imm = imm_u;
      end
      // link value pc+4 comes out of the alu
      OPC_JAL: begin
        dec_o.op1       = pc_i;
        dec_o.op2       = 32'd4;
        dec_o.imm       = imm_j;
        dec_o.is_jump   = 1'b1;
        dec_o.jump_base = pc_i;
      end
      OPC_JALR: begin
        dec_o.op1       = pc_i;
        dec_o.op2       = 32'd4;
        dec_o.imm       = imm_i;
        dec_o.is_jump   = 1'b1;
        dec_o.jump_base = rs1_val_i;
      end
      // branches subtract and never write back
      OPC_BRANCH: begin
        dec_o.op1       = rs1_val_i;
        dec_o.op2       = rs2_val_i;
        dec_o.imm       = imm_b;
        dec_o.is_branch = 1'b1;
        dec_o.jump_base = pc_i;
        dec_o.alu_op    = ALU_SUB;
        dec_o.wen       = 1'b0;
      end
      OPC_OP_IMM: begin
        dec_o.op1    = rs1_val_i;
        dec_o.op2    = imm_i;
        dec_o.imm    = imm_i;
        // only the right shift looks at bit 30, srai vs srli
        dec_o.alu_op = alu_op_e'({(funct3 == 3'b101) & funct7[5], funct3});
      end
      OPC_OP: begin
        dec_o.op1    = rs1_val_i;
        dec_o.op2    = rs2_val_i;
        dec_o.alu_op = alu_op_e'({funct7[5], funct3});
      end
      default: begin
        dec_o.illegal = 1'b1;
        dec_o.wen     = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* regfile_sb.sv */
`timescale 1ns/1ns
`default_nettype none

module regfile_sb (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic [isa_pkg::REG_IDX_W-1:0] rd_idx1_i,
  input  wire logic [isa_pkg::REG_IDX_W-1:0] rd_idx2_i,
  output      logic [isa_pkg::XLEN-1:0]      rd_val1_o,
  output      logic [isa_pkg::XLEN-1:0]      rd_val2_o,
  output      logic                          busy1_o,
  output      logic                          busy2_o,
  input  wire logic                          set_busy_i,
  input  wire logic [isa_pkg::REG_IDX_W-1:0] set_idx_i,
  input  wire logic                          wr_en_i,
  input  wire logic [isa_pkg::REG_IDX_W-1:0] wr_idx_i,
  input  wire logic [isa_pkg::XLEN-1:0]      wr_val_i
);
  import isa_pkg::*;

  // x0 has no storage
  logic [XLEN-1:0]         regs_q [1:2**REG_IDX_W-1];
  // bit 0 is never set
  logic [2**REG_IDX_W-1:0] busy_q;

  // asynchronous read, x0 reads zero
  assign rd_val1_o = (rd_idx1_i == '0) ? '0 : regs_q[rd_idx1_i];
  assign rd_val2_o = (rd_idx2_i == '0) ? '0 : regs_q[rd_idx2_i];
  assign busy1_o   = busy_q[rd_idx1_i];
  assign busy2_o   = busy_q[rd_idx2_i];

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
      for (int i = 1; i < 2**REG_IDX_W; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      if (wr_en_i && wr_idx_i != '0) begin
        regs_q[wr_idx_i] <= wr_val_i;
        busy_q[wr_idx_i] <= 1'b0;
      end
      // set comes last so it wins over a clear on the same edge
      if (set_busy_i && set_idx_i != '0) begin
        busy_q[set_idx_i] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* idu.sv */
`timescale 1ns/1ns
`default_nettype none

module idu (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic                          issue_valid_i,
  output      logic                          issue_ready_o,
  input  wire pipe_pkg::issue_t              issue_i,
  output      logic [isa_pkg::REG_IDX_W-1:0] rf_idx1_o,
  output      logic [isa_pkg::REG_IDX_W-1:0] rf_idx2_o,
  input  wire logic [isa_pkg::XLEN-1:0]      rf_val1_i,
  input  wire logic [isa_pkg::XLEN-1:0]      rf_val2_i,
  input  wire logic                          busy1_i,
  input  wire logic                          busy2_i,
  output      logic                          set_busy_o,
  output      logic [isa_pkg::REG_IDX_W-1:0] set_idx_o,
  input  wire logic                          fwd_valid_i,
  input  wire logic [isa_pkg::REG_IDX_W-1:0] fwd_rd_i,
  input  wire logic [isa_pkg::XLEN-1:0]      fwd_value_i,
  output      logic                          dec_valid_o,
  input  wire logic                          dec_ready_i,
  output      pipe_pkg::dec_t                dec_o
);
  import isa_pkg::*;
  import pipe_pkg::*;

  issue_t               cur_q;
  logic                 valid_q;
  opcode_e              opcode;
  logic [REG_IDX_W-1:0] rs1;
  logic [REG_IDX_W-1:0] rs2;
  logic                 need1;
  logic                 need2;
  logic                 hit1;
  logic                 hit2;
  logic                 hazard;
  logic                 leave;
  logic [XLEN-1:0]      src1;
  logic [XLEN-1:0]      src2;

  assign opcode = opcode_e'(cur_q.inst[6:0]);
  // upper bit of each register field ignored
  assign rs1    = cur_q.inst[18:15];
  assign rs2    = cur_q.inst[23:20];

  // lui, auipc, jal and illegal words read no register
  assign need1 = opcode inside {OPC_JALR, OPC_BRANCH, OPC_OP_IMM, OPC_OP};
  assign need2 = opcode inside {OPC_BRANCH, OPC_OP};

  // the instruction in the alu register covers its own busy bit
  assign hit1 = fwd_valid_i && rs1 != '0 && rs1 == fwd_rd_i;
  assign hit2 = fwd_valid_i && rs2 != '0 && rs2 == fwd_rd_i;
  assign src1 = hit1 ? fwd_value_i : rf_val1_i;
  assign src2 = hit2 ? fwd_value_i : rf_val2_i;

  // still busy and not forwardable means the producer sits in retire
  assign hazard = (need1 && rs1 != '0 && busy1_i && !hit1) ||
                  (need2 && rs2 != '0 && busy2_i && !hit2);

  assign rf_idx1_o = rs1;
  assign rf_idx2_o = rs2;

  assign dec_valid_o   = valid_q && !hazard;
  assign leave         = dec_valid_o && dec_ready_i;
  assign issue_ready_o = !valid_q || leave;

  // mark rd pending as the instruction enters execute
  assign set_busy_o = leave && dec_o.wen;
  assign set_idx_o  = dec_o.rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (issue_ready_o) begin
      valid_q <= issue_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid_i && issue_ready_o) begin
      cur_q <= issue_i;
    end
  end

  idu_decoder u_decoder (
    .inst_i    (cur_q.inst),
    .pc_i      (cur_q.pc),
    .rs1_val_i (src1),
    .rs2_val_i (src2),
    .dec_o     (dec_o)
  );

endmodule

`default_nettype wire

/* exu.sv */
`timescale 1ns/1ns
`default_nettype none

module exu (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic                          dec_valid_i,
  output      logic                          dec_ready_o,
  input  wire pipe_pkg::dec_t                dec_i,
  output      logic                          fwd_valid_o,
  output      logic [isa_pkg::REG_IDX_W-1:0] fwd_rd_o,
  output      logic [isa_pkg::XLEN-1:0]      fwd_value_o,
  output      logic                          retire_valid_o,
  input  wire logic                          retire_ready_i,
  output      pipe_pkg::retire_t             retire_o,
  output      logic                          wb_en_o,
  output      logic [isa_pkg::REG_IDX_W-1:0] wb_idx_o,
  output      logic [isa_pkg::XLEN-1:0]      wb_val_o
);
  import isa_pkg::*;
  import pipe_pkg::*;

  dec_t            alu_q;
  logic [XLEN-1:0] alu_res_q;
  logic            alu_valid_q;
  retire_t         ret_q;
  retire_t         ret_d;
  logic            ret_valid_q;
  logic            ret_ready;
  logic [XLEN-1:0] target_sum;

  function automatic logic [XLEN-1:0] alu_calc(input alu_op_e op,
                                               input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b);
    case (op)
      ALU_SUB:  return a - b;
      ALU_SLL:  return a << b[4:0];
      ALU_SLT:  return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU: return {{(XLEN-1){1'b0}}, a < b};
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return $signed(a) >>> b[4:0];
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      default:  return a + b;
    endcase
  endfunction

  function automatic logic br_taken(input br_fn_e fn,
                                    input logic [XLEN-1:0] a,
                                    input logic [XLEN-1:0] b);
    case (fn)
      BR_BEQ:  return a == b;
      BR_BNE:  return a != b;
      BR_BLT:  return $signed(a) < $signed(b);
      BR_BGE:  return $signed(a) >= $signed(b);
      BR_BLTU: return a < b;
      BR_BGEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // retire register frees up when empty or handing off this cycle
  assign ret_ready   = !ret_valid_q || retire_ready_i;
  assign dec_ready_o = !alu_valid_q || ret_ready;

  // forward only what will write a register
  assign fwd_valid_o = alu_valid_q && alu_q.wen;
  assign fwd_rd_o    = alu_q.rd;
  assign fwd_value_o = alu_res_q;

  assign target_sum = alu_q.jump_base + alu_q.imm;

  always_comb begin
    ret_d         = '0;
    ret_d.pc      = alu_q.pc;
    ret_d.rd      = alu_q.rd;
    ret_d.wen     = alu_q.wen;
    ret_d.value   = alu_res_q;
    ret_d.illegal = alu_q.illegal;
    if (alu_q.is_branch) begin
      ret_d.taken  = br_taken(alu_q.br_fn, alu_q.op1, alu_q.op2);
      ret_d.target = target_sum;
    end else if (alu_q.is_jump) begin
      ret_d.taken  = 1'b1;
      // jal targets are even already, the clear is for jalr
      ret_d.target = {target_sum[XLEN-1:1], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      alu_valid_q <= 1'b0;
      ret_valid_q <= 1'b0;
    end else begin
      if (dec_ready_o) begin
        alu_valid_q <= dec_valid_i;
      end
      if (ret_ready) begin
        ret_valid_q <= alu_valid_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid_i && dec_ready_o) begin
      alu_q     <= dec_i;
      alu_res_q <= alu_calc(dec_i.alu_op, dec_i.op1, dec_i.op2);
    end
    if (alu_valid_q && ret_ready) begin
      ret_q <= ret_d;
    end
  end

  assign retire_valid_o = ret_valid_q;
  assign retire_o       = ret_q;

  // a younger writer of the same rd in the alu register makes this write dead
  // skipping it keeps the busy bit set until that writer retires
  assign wb_en_o  = ret_valid_q && retire_ready_i && ret_q.wen &&
                    !(alu_valid_q && alu_q.wen && alu_q.rd == ret_q.rd);
  assign wb_idx_o = ret_q.rd;
  assign wb_val_o = ret_q.value;

endmodule

`default_nettype wire

/* core_top.sv */
`timescale 1ns/1ns
`default_nettype none

module core_top (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              issue_valid_i,
  output      logic              issue_ready_o,
  input  wire pipe_pkg::issue_t  issue_i,
  output      logic              retire_valid_o,
  input  wire logic              retire_ready_i,
  output      pipe_pkg::retire_t retire_o
);
  import isa_pkg::*;
  import pipe_pkg::*;

  // decode to execute
  logic                 dec_valid;
  logic                 dec_ready;
  dec_t                 dec;
  // register file read side
  logic [REG_IDX_W-1:0] rf_idx1;
  logic [REG_IDX_W-1:0] rf_idx2;
  logic [XLEN-1:0]      rf_val1;
  logic [XLEN-1:0]      rf_val2;
  logic                 busy1;
  logic                 busy2;
  logic                 set_busy;
  logic [REG_IDX_W-1:0] set_idx;
  // forward path out of the alu register
  logic                 fwd_valid;
  logic [REG_IDX_W-1:0] fwd_rd;
  logic [XLEN-1:0]      fwd_value;
  // writeback on retire
  logic                 wb_en;
  logic [REG_IDX_W-1:0] wb_idx;
  logic [XLEN-1:0]      wb_val;

  idu u_idu (
    .clk           (clk),
    .rst           (rst),
    .issue_valid_i (issue_valid_i),
    .issue_ready_o (issue_ready_o),
    .issue_i       (issue_i),
    .rf_idx1_o     (rf_idx1),
    .rf_idx2_o     (rf_idx2),
    .rf_val1_i     (rf_val1),
    .rf_val2_i     (rf_val2),
    .busy1_i       (busy1),
    .busy2_i       (busy2),
    .set_busy_o    (set_busy),
    .set_idx_o     (set_idx),
    .fwd_valid_i   (fwd_valid),
    .fwd_rd_i      (fwd_rd),
    .fwd_value_i   (fwd_value),
    .dec_valid_o   (dec_valid),
    .dec_ready_i   (dec_ready),
    .dec_o         (dec)
  );

  regfile_sb u_regfile_sb (
    .clk        (clk),
    .rst        (rst),
    .rd_idx1_i  (rf_idx1),
    .rd_idx2_i  (rf_idx2),
    .rd_val1_o  (rf_val1),
    .rd_val2_o  (rf_val2),
    .busy1_o    (busy1),
    .busy2_o    (busy2),
    .set_busy_i (set_busy),
    .set_idx_i  (set_idx),
    .wr_en_i    (wb_en),
    .wr_idx_i   (wb_idx),
    .wr_val_i   (wb_val)
  );

  exu u_exu (
    .clk            (clk),
    .rst            (rst),
    .dec_valid_i    (dec_valid),
    .dec_ready_o    (dec_ready),
    .dec_i          (dec),
    .fwd_valid_o    (fwd_valid),
    .fwd_rd_o       (fwd_rd),
    .fwd_value_o    (fwd_value),
    .retire_valid_o (retire_valid_o),
    .retire_ready_i (retire_ready_i),
    .retire_o       (retire_o),
    .wb_en_o        (wb_en),
    .wb_idx_o       (wb_idx),
    .wb_val_o       (wb_val)
  );

endmodule

`default_nettype wire

/* tb_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_core;
  import pipe_pkg::*;

  // rv32 major opcodes as the isa manual lists them
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [31:0] PC_BASE   = 32'h100;

  logic     clk = 1'b0;
  logic     rst;
  logic     issue_valid_i;
  logic     issue_ready_o;
  issue_t   issue_i;
  logic     retire_valid_o;
  logic     retire_ready_i;
  retire_t  retire_o;

  // stimulus table and the expected retire record per row
  logic [31:0] inst_q[$];
  logic [31:0] pc_q[$];
  retire_t     exp_q[$];
  logic        has_tgt_q[$];
  // in-order register model
  logic [31:0] ref_regs[16];

  int errors = 0;
  int ret_count = 0;
  int cycles = 0;
  int limit;
  int rnd;

  core_top DUT (
    .clk            (clk),
    .rst            (rst),
    .issue_valid_i  (issue_valid_i),
    .issue_ready_o  (issue_ready_o),
    .issue_i        (issue_i),
    .retire_valid_o (retire_valid_o),
    .retire_ready_i (retire_ready_i),
    .retire_o       (retire_o)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  // retire back-pressure holds ready low about a third of the time
  task automatic drive_retire_ready();
    forever begin
      @(posedge clk);
      #2;
      retire_ready_i = ($urandom_range(2) != 0);
    end
  endtask

  // instruction assemblers
  function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                         input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input int imm, input int rs1, input logic [2:0] f3,
                                         input int rd, input logic [6:0] opc);
    return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input int rd,
                                         input logic [6:0] opc);
    return {imm, 5'(rd), opc};
  endfunction

  function automatic logic [31:0] b_type(input int off, input int rs2, input int rs1,
                                         input logic [2:0] f3);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] j_type(input int off, input int rd);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), OPC_JAL};
  endfunction

  task automatic add_row(input logic [31:0] w);
    pc_q.push_back(PC_BASE + 32'(4 * inst_q.size()));
    inst_q.push_back(w);
  endtask

  task automatic fill_table();
    // immediate arithmetic
    add_row(u_type(20'h12345, 1, OPC_LUI));
    add_row(u_type(20'h00001, 2, OPC_AUIPC));
    add_row(i_type(-5, 0, 3'b000, 3, OPC_OP_IMM));
    add_row(i_type('h678, 1, 3'b000, 4, OPC_OP_IMM));
    add_row(i_type(1, 3, 3'b010, 5, OPC_OP_IMM));
    add_row(i_type(1, 3, 3'b011, 6, OPC_OP_IMM));
    add_row(i_type('h0f0, 3, 3'b100, 7, OPC_OP_IMM));
    add_row(i_type('h00f, 1, 3'b110, 8, OPC_OP_IMM));
    add_row(i_type('h7f0, 3, 3'b111, 9, OPC_OP_IMM));
    add_row(i_type(4, 3, 3'b001, 10, OPC_OP_IMM));
    // srli then srai told apart by bit 30
    add_row(i_type(4, 3, 3'b101, 11, OPC_OP_IMM));
    add_row(i_type('h404, 3, 3'b101, 12, OPC_OP_IMM));
    // x0 write then x0 read back
    add_row(i_type(5, 1, 3'b000, 0, OPC_OP_IMM));
    add_row(r_type(7'h00, 4, 0, 3'b000, 13));
    // register-register
    add_row(r_type(7'h00, 3, 1, 3'b000, 14));
    add_row(r_type(7'h20, 3, 1, 3'b000, 15));
    add_row(r_type(7'h00, 7, 4, 3'b001, 13));
    add_row(r_type(7'h00, 1, 3, 3'b010, 14));
    add_row(r_type(7'h00, 1, 3, 3'b011, 15));
    add_row(r_type(7'h00, 3, 1, 3'b100, 5));
    add_row(r_type(7'h00, 10, 3, 3'b101, 6));
    add_row(r_type(7'h20, 10, 3, 3'b101, 7));
    add_row(r_type(7'h00, 3, 1, 3'b110, 8));
    add_row(r_type(7'h00, 3, 1, 3'b111, 9));
    // back-to-back chains at distance one and two
    add_row(i_type(100, 0, 3'b000, 1, OPC_OP_IMM));
    add_row(i_type(1, 1, 3'b000, 1, OPC_OP_IMM));
    add_row(r_type(7'h00, 1, 1, 3'b000, 2));
    add_row(i_type(7, 0, 3'b000, 3, OPC_OP_IMM));
    add_row(i_type(9, 0, 3'b000, 4, OPC_OP_IMM));
    add_row(r_type(7'h00, 1, 3, 3'b000, 5));
    add_row(r_type(7'h20, 5, 2, 3'b000, 6));
    add_row(i_type(-1, 0, 3'b000, 10, OPC_OP_IMM));
    // each branch taken then not taken with x1=101 x3=7 x10=-1
    add_row(b_type(16, 1, 1, 3'b000));
    add_row(b_type(-8, 3, 1, 3'b000));
    add_row(b_type(32, 3, 1, 3'b001));
    add_row(b_type(12, 3, 3, 3'b001));
    add_row(b_type(8, 3, 10, 3'b100));
    add_row(b_type(8, 10, 3, 3'b100));
    add_row(b_type(-16, 10, 3, 3'b101));
    add_row(b_type(20, 3, 10, 3'b101));
    add_row(b_type(24, 10, 3, 3'b110));
    add_row(b_type(24, 3, 10, 3'b110));
    add_row(b_type(-32, 3, 10, 3'b111));
    add_row(b_type(4, 10, 3, 3'b111));
    // jumps where both jalr sums are odd to see bit 0 cleared
    add_row(j_type(2048, 11));
    add_row(i_type(4, 1, 3'b000, 12, OPC_JALR));
    add_row(i_type(-7, 11, 3'b000, 13, OPC_JALR));
    add_row(j_type(-64, 0));
    // a load and an all-ones word are both illegal here
    add_row(i_type(0, 1, 3'b010, 14, OPC_LOAD));
    add_row(32'hffff_ffff);
    add_row(r_type(7'h00, 0, 14, 3'b000, 15));
    add_row(i_type(0, 15, 3'b000, 9, OPC_OP_IMM));
  endtask

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return {31'b0, $signed(a) < $signed(b)};
      3'b011: return {31'b0, a < b};
      3'b100: return a ^ b;
      3'b110: return a | b;
      3'b111: return a & b;
      default: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
    endcase
  endfunction

  function automatic logic cond_ref(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  // expected retire record of one row and its register update
  task automatic model_row(input int idx);
    logic [31:0] w;
    logic [31:0] pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        tgt;
    retire_t     e;
    w     = inst_q[idx];
    pc    = pc_q[idx];
    a     = ref_regs[w[18:15]];
    b     = ref_regs[w[23:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    tgt   = 1'b0;
    e     = '0;
    e.pc  = pc;
    e.rd  = w[10:7];
    e.wen = 1'b1;
    case (w[6:0])
      OPC_LUI:    e.value = {w[31:12], 12'b0};
      OPC_AUIPC:  e.value = pc + {w[31:12], 12'b0};
      OPC_OP_IMM: e.value = alu_ref(w[14:12], w[30] && w[14:12] == 3'b101, a, imm_i);
      OPC_OP:     e.value = alu_ref(w[14:12], w[30], a, b);
      OPC_JAL: begin
        e.value  = pc + 32'd4;
        e.taken  = 1'b1;
        e.target = pc + imm_j;
        tgt      = 1'b1;
      end
      OPC_JALR: begin
        e.value  = pc + 32'd4;
        e.taken  = 1'b1;
        e.target = (a + imm_i) & ~32'd1;
        tgt      = 1'b1;
      end
      OPC_BRANCH: begin
        e.wen    = 1'b0;
        e.taken  = cond_ref(w[14:12], a, b);
        e.target = pc + imm_b;
        tgt      = 1'b1;
      end
      default: begin
        e.wen     = 1'b0;
        e.illegal = 1'b1;
      end
    endcase
    if (e.wen && e.rd != 4'd0) begin
      ref_regs[e.rd] = e.value;
    end
    exp_q.push_back(e);
    has_tgt_q.push_back(tgt);
  endtask

  task automatic check_field(input int idx, input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    if (got !== exp) begin
      errors++;
      $display("ERR row %0d %s exp %h got %h", idx, name, exp, got);
    end
  endtask

  task automatic check_retire(input int idx);
    retire_t e;
    e = exp_q[idx];
    check_field(idx, "retire_o.pc", e.pc, retire_o.pc);
    check_field(idx, "retire_o.rd", 32'(e.rd), 32'(retire_o.rd));
    check_field(idx, "retire_o.wen", 32'(e.wen), 32'(retire_o.wen));
    check_field(idx, "retire_o.illegal", 32'(e.illegal), 32'(retire_o.illegal));
    check_field(idx, "retire_o.taken", 32'(e.taken), 32'(retire_o.taken));
    // value is architectural only when written back
    if (e.wen) begin
      check_field(idx, "retire_o.value", e.value, retire_o.value);
    end
    if (has_tgt_q[idx]) begin
      check_field(idx, "retire_o.target", e.target, retire_o.target);
    end
  endtask

  // monitor samples on the edge where the transfer happens
  always @(posedge clk) begin
    if (!rst && retire_valid_o && retire_ready_i) begin
      if (ret_count < exp_q.size()) begin
        check_retire(ret_count);
      end else begin
        errors++;
        $display("retire beyond the end of the table, pc %h", retire_o.pc);
      end
      ret_count++;
    end
  end

  task automatic issue_rows();
    for (int i = 0; i < inst_q.size(); i++) begin
      // random idle gap before each instruction
      while ($urandom_range(3) == 0) begin
        @(posedge clk);
        #2;
      end
      issue_valid_i = 1'b1;
      issue_i.inst  = inst_q[i];
      issue_i.pc    = pc_q[i];
      @(posedge clk);
      while (!issue_ready_o) begin
        @(posedge clk);
      end
      #2;
      issue_valid_i = 1'b0;
      issue_i       = '0;
    end
  endtask

  initial begin
    rnd            = $urandom(38);
    rst            = 1'b1;
    issue_valid_i  = 1'b0;
    issue_i        = '0;
    retire_ready_i = 1'b0;
    for (int r = 0; r < 16; r++) begin
      ref_regs[r] = '0;
    end
    fill_table();
    for (int i = 0; i < inst_q.size(); i++) begin
      model_row(i);
    end
    limit = 40 * inst_q.size();
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    // state straight out of reset
    if (issue_ready_o !== 1'b1) begin
      errors++;
      $display("ERR issue_ready_o exp %h got %h", 1'b1, issue_ready_o);
    end
    if (retire_valid_o !== 1'b0) begin
      errors++;
      $display("ERR retire_valid_o exp %h got %h", 1'b0, retire_valid_o);
    end
    fork
      issue_rows();
      drive_retire_ready();
    join_none
    while (ret_count < inst_q.size() && cycles < limit) begin
      @(posedge clk);
    end
    if (ret_count < inst_q.size()) begin
      errors++;
      $display("timeout after %0d cycles, retire stopped early", cycles);
    end else begin
      // drain window to catch stray retires
      repeat (10) @(posedge clk);
    end
    $display("retired %0d of %0d rows, errors %0d", ret_count, inst_q.size(), errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
isa_pkg.sv
pipe_pkg.sv
idu_decoder.sv
regfile_sb.sv
idu.sv
exu.sv
core_top.sv
tb_core.sv

/* Bender.yml */
package:
  name: rv32e_decode_execute

sources:
  - isa_pkg.sv
  - pipe_pkg.sv
  - idu_decoder.sv
  - regfile_sb.sv
  - idu.sv
  - exu.sv
  - core_top.sv
  - target: test
    files:
      - tb_core.sv
